//--- src/cpuPkg.sv
package cpuPkg;

    typedef logic [31:0] word_t;      // data, address or instruction word
    typedef logic [4:0]  regAddr_t;
    typedef logic [4:0]  shamt_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_LUI
    } aluOp_e;

    // operand source for the D stage
    typedef enum logic [2:0] {
        FWD_RF,
        FWD_E1,
        FWD_E2,
        FWD_M1,
        FWD_M2,
        FWD_W1,
        FWD_W2
    } fwdSel_e;

    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_ORI     = 6'h0D;
    localparam logic [5:0] OP_LUI     = 6'h0F;

    localparam logic [5:0] FN_SLL     = 6'h00;
    localparam logic [5:0] FN_ADDU    = 6'h21;
    localparam logic [5:0] FN_SUBU    = 6'h23;
    localparam logic [5:0] FN_AND     = 6'h24;
    localparam logic [5:0] FN_OR      = 6'h25;
    localparam logic [5:0] FN_XOR     = 6'h26;
    localparam logic [5:0] FN_SLT     = 6'h2A;

    localparam word_t RESET_PC   = 32'hBFC0_0000;
    localparam word_t FETCH_STEP = 32'd8;    // full pair
    localparam word_t INST_STEP  = 32'd4;    // one word, used after a split

endpackage

//--- src/fetchUnit.sv
`timescale 1ns/10ps

module fetchUnit (
    input  logic          clk,
    input  logic          rstN_i,
    input  logic          stallF_i,
    input  logic          flushF2_i,
    input  logic          redirect_i,
    input  cpuPkg::word_t redirectPc_i,
    input  cpuPkg::word_t inst1_i,
    input  cpuPkg::word_t inst2_i,
    output cpuPkg::word_t pc_o,
    output logic          instEn_o,
    output cpuPkg::word_t pcF2_o,
    output cpuPkg::word_t inst1F2_o,
    output cpuPkg::word_t inst2F2_o,
    output logic          validF2_o
);

    cpuPkg::word_t pcNext;

    // no request on the edge that redirects, that pair is dropped anyway
    assign instEn_o = ~redirect_i;

    always_comb begin
        if (redirect_i) begin
            pcNext = redirectPc_i;
        end else if (stallF_i) begin
            pcNext = pc_o;
        end else begin
            pcNext = pc_o + cpuPkg::FETCH_STEP;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            pc_o      <= cpuPkg::RESET_PC;
            validF2_o <= 1'b0;
        end else begin
            pc_o <= pcNext;
            if (flushF2_i) begin
                validF2_o <= 1'b0;          // pending fetch is stale
            end else if (!stallF_i) begin
                validF2_o <= instEn_o;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stallF_i) begin
            pcF2_o <= pc_o;
        end
    end

    // ROM words only count when a request was made
    assign inst1F2_o = validF2_o ? inst1_i : '0;
    assign inst2F2_o = validF2_o ? inst2_i : '0;

    pcAligned: assert property (@(posedge clk) disable iff (!rstN_i) pc_o[1:0] == 2'b00)
        else $error("fetch PC lost word alignment");

endmodule

//--- src/instDecoder.sv
`timescale 1ns/10ps

module instDecoder (
    input  cpuPkg::word_t    instr_i,
    output cpuPkg::aluOp_e   aluOp_o,
    output logic             useImm_o,
    output cpuPkg::word_t    imm_o,
    output cpuPkg::shamt_t   shamt_o,
    output cpuPkg::regAddr_t rs_o,
    output cpuPkg::regAddr_t rt_o,
    output logic             readsRs_o,
    output logic             readsRt_o,
    output cpuPkg::regAddr_t writeReg_o,
    output logic             regWrite_o
);

    logic [5:0]  opcode;
    logic [5:0]  funct;
    logic [15:0] imm16;
    logic        known;

    assign opcode  = instr_i[31:26];
    assign funct   = instr_i[5:0];
    assign imm16   = instr_i[15:0];
    assign rs_o    = instr_i[25:21];
    assign rt_o    = instr_i[20:16];
    assign shamt_o = instr_i[10:6];

    always_comb begin
        aluOp_o    = cpuPkg::ALU_ADD;
        useImm_o   = 1'b0;
        imm_o      = '0;
        readsRs_o  = 1'b0;
        readsRt_o  = 1'b0;
        writeReg_o = instr_i[20:16];       // rt for the immediate forms
        known      = 1'b0;
        case (opcode)
            cpuPkg::OP_SPECIAL: begin
                writeReg_o = instr_i[15:11];
                readsRs_o  = 1'b1;
                readsRt_o  = 1'b1;
                known      = 1'b1;
                case (funct)
                    cpuPkg::FN_ADDU: aluOp_o = cpuPkg::ALU_ADD;
                    cpuPkg::FN_SUBU: aluOp_o = cpuPkg::ALU_SUB;
                    cpuPkg::FN_AND:  aluOp_o = cpuPkg::ALU_AND;
                    cpuPkg::FN_OR:   aluOp_o = cpuPkg::ALU_OR;
                    cpuPkg::FN_XOR:  aluOp_o = cpuPkg::ALU_XOR;
                    cpuPkg::FN_SLT:  aluOp_o = cpuPkg::ALU_SLT;
                    cpuPkg::FN_SLL: begin
                        aluOp_o   = cpuPkg::ALU_SLL;
                        readsRs_o = 1'b0;  // shamt field replaces rs
                    end
                    default: begin
                        known     = 1'b0;
                        readsRs_o = 1'b0;
                        readsRt_o = 1'b0;
                    end
                endcase
            end
            cpuPkg::OP_ADDIU: begin
                useImm_o  = 1'b1;
                imm_o     = {{16{imm16[15]}}, imm16};
                readsRs_o = 1'b1;
                known     = 1'b1;
            end
            cpuPkg::OP_ORI: begin
                aluOp_o   = cpuPkg::ALU_OR;
                useImm_o  = 1'b1;
                imm_o     = {16'h0000, imm16};
                readsRs_o = 1'b1;
                known     = 1'b1;
            end
            cpuPkg::OP_LUI: begin
                aluOp_o  = cpuPkg::ALU_LUI;
                useImm_o = 1'b1;
                imm_o    = {imm16, 16'h0000};
                known    = 1'b1;
            end
            default: ;
        endcase
    end

    // unknown opcodes and r0 targets behave as a NOP
    assign regWrite_o = known && (writeReg_o != '0);

endmodule

//--- src/regFile.sv
`timescale 1ns/10ps

module regFile (
    input  logic             clk,
    input  logic             rstN_i,
    input  logic             we1_i,
    input  logic             we2_i,
    input  cpuPkg::regAddr_t waddr1_i,
    input  cpuPkg::regAddr_t waddr2_i,
    input  cpuPkg::word_t    wdata1_i,
    input  cpuPkg::word_t    wdata2_i,
    input  cpuPkg::regAddr_t raddr1_i, raddr2_i, raddr3_i, raddr4_i,
    output cpuPkg::word_t    rdata1_o, rdata2_o, rdata3_o, rdata4_o
);

    cpuPkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (we1_i) begin
                regs[waddr1_i] <= wdata1_i;
            end
            if (we2_i) begin
                regs[waddr2_i] <= wdata2_i;    // slave is younger, its write lands last
            end
        end
    end

    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];
    assign rdata3_o = (raddr3_i == '0) ? '0 : regs[raddr3_i];
    assign rdata4_o = (raddr4_i == '0) ? '0 : regs[raddr4_i];

endmodule

//--- src/issueCtrl.sv
`timescale 1ns/10ps

module issueCtrl (
    input  logic             iCacheStall_i,
    input  logic             validD_i,
    input  logic             regWrite1_i,
    input  cpuPkg::regAddr_t writeReg1_i,
    input  cpuPkg::regAddr_t rs2_i,
    input  cpuPkg::regAddr_t rt2_i,
    input  logic             readsRs2_i,
    input  logic             readsRt2_i,
    input  cpuPkg::word_t    pcD_i,
    output logic             stallF_o,
    output logic             stallD_o,
    output logic             flushF2_o,
    output logic             bubble2_o,
    output logic             bubbleE_o,
    output logic             redirect_o,
    output cpuPkg::word_t    redirectPc_o
);

    logic dependent;
    logic split;

    // slave needs what the master produces in the same cycle
    assign dependent = regWrite1_i &&
                       ((readsRs2_i && (rs2_i == writeReg1_i)) ||
                        (readsRt2_i && (rt2_i == writeReg1_i)));

    assign split = validD_i && dependent && !iCacheStall_i;   // held pair retries later

    assign stallF_o  = iCacheStall_i;
    assign stallD_o  = iCacheStall_i;
    assign bubbleE_o = iCacheStall_i;

    // master goes alone, slave is refetched as the next master
    assign bubble2_o    = split;
    assign flushF2_o    = split;
    assign redirect_o   = split;
    assign redirectPc_o = pcD_i + cpuPkg::INST_STEP;

endmodule

//--- src/bypassNet.sv
`timescale 1ns/10ps

module bypassNet (
    input  cpuPkg::regAddr_t raddrA1_i, raddrB1_i, raddrA2_i, raddrB2_i,
    input  logic             useA1_i, useB1_i, useA2_i, useB2_i,
    input  cpuPkg::word_t    rdataA1_i, rdataB1_i, rdataA2_i, rdataB2_i,
    input  cpuPkg::regAddr_t wregE1_i, wregM1_i, wregW1_i,
    input  cpuPkg::regAddr_t wregE2_i, wregM2_i, wregW2_i,
    input  logic             wenE1_i, wenM1_i, wenW1_i,
    input  logic             wenE2_i, wenM2_i, wenW2_i,
    input  cpuPkg::word_t    resE1_i, resM1_i, resW1_i,
    input  cpuPkg::word_t    resE2_i, resM2_i, resW2_i,
    output cpuPkg::word_t    opA1_o, opB1_o, opA2_o, opB2_o
);

    cpuPkg::fwdSel_e selA1, selB1, selA2, selB2;

    // youngest producer first, lane 2 ahead of lane 1 inside a stage
    function automatic cpuPkg::fwdSel_e pickSrc(input cpuPkg::regAddr_t addr, input logic rdEn);
        if (!rdEn || addr == '0) begin
            return cpuPkg::FWD_RF;
        end else if (wenE2_i && wregE2_i == addr) begin
            return cpuPkg::FWD_E2;
        end else if (wenE1_i && wregE1_i == addr) begin
            return cpuPkg::FWD_E1;
        end else if (wenM2_i && wregM2_i == addr) begin
            return cpuPkg::FWD_M2;
        end else if (wenM1_i && wregM1_i == addr) begin
            return cpuPkg::FWD_M1;
        end else if (wenW2_i && wregW2_i == addr) begin
            return cpuPkg::FWD_W2;
        end else if (wenW1_i && wregW1_i == addr) begin
            return cpuPkg::FWD_W1;
        end
        return cpuPkg::FWD_RF;
    endfunction

    function automatic cpuPkg::word_t muxSrc(input cpuPkg::fwdSel_e sel, input cpuPkg::word_t rf);
        case (sel)
            cpuPkg::FWD_E1: return resE1_i;
            cpuPkg::FWD_E2: return resE2_i;
            cpuPkg::FWD_M1: return resM1_i;
            cpuPkg::FWD_M2: return resM2_i;
            cpuPkg::FWD_W1: return resW1_i;
            cpuPkg::FWD_W2: return resW2_i;
            default:        return rf;
        endcase
    endfunction

    always_comb begin
        selA1  = pickSrc(raddrA1_i, useA1_i);
        selB1  = pickSrc(raddrB1_i, useB1_i);
        selA2  = pickSrc(raddrA2_i, useA2_i);
        selB2  = pickSrc(raddrB2_i, useB2_i);
        opA1_o = muxSrc(selA1, rdataA1_i);
        opB1_o = muxSrc(selB1, rdataB1_i);
        opA2_o = muxSrc(selA2, rdataA2_i);
        opB2_o = muxSrc(selB2, rdataB2_i);
    end

endmodule

//--- src/execLane.sv
`timescale 1ns/10ps

module execLane (
    input  logic             clk,
    input  logic             rstN_i,
    input  logic             bubble_i,
    input  logic             valid_i,
    input  cpuPkg::word_t    pc_i,
    input  cpuPkg::aluOp_e   aluOp_i,
    input  cpuPkg::word_t    opA_i,
    input  cpuPkg::word_t    opB_i,
    input  cpuPkg::word_t    imm_i,
    input  logic             useImm_i,
    input  cpuPkg::shamt_t   shamt_i,
    input  cpuPkg::regAddr_t writeReg_i,
    input  logic             regWrite_i,
    output cpuPkg::word_t    resE_o, resM_o, resW_o,
    output cpuPkg::regAddr_t wregE_o, wregM_o, wregW_o,
    output logic             wenE_o, wenM_o, wenW_o,
    output cpuPkg::word_t    pcW_o
);

    logic           validE, validM, validW;
    logic           regWriteE, regWriteM, regWriteW;
    cpuPkg::aluOp_e aluOpE;
    cpuPkg::word_t  srcA, srcB;
    cpuPkg::shamt_t shamtE;
    cpuPkg::word_t  pcE, pcM;

    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            validE <= 1'b0;
            validM <= 1'b0;
            validW <= 1'b0;
        end else begin
            validE <= valid_i && !bubble_i;
            validM <= validE;
            validW <= validM;
        end
    end

    always_ff @(posedge clk) begin
        aluOpE    <= aluOp_i;
        srcA      <= opA_i;
        srcB      <= useImm_i ? imm_i : opB_i;
        shamtE    <= shamt_i;
        wregE_o   <= writeReg_i;
        regWriteE <= regWrite_i;
        pcE       <= pc_i;
        resM_o    <= resE_o;                // M only carries the result
        wregM_o   <= wregE_o;
        regWriteM <= regWriteE;
        pcM       <= pcE;
        resW_o    <= resM_o;
        wregW_o   <= wregM_o;
        regWriteW <= regWriteM;
        pcW_o     <= pcM;
    end

    always_comb begin
        case (aluOpE)
            cpuPkg::ALU_ADD: resE_o = srcA + srcB;
            cpuPkg::ALU_SUB: resE_o = srcA - srcB;
            cpuPkg::ALU_AND: resE_o = srcA & srcB;
            cpuPkg::ALU_OR:  resE_o = srcA | srcB;
            cpuPkg::ALU_XOR: resE_o = srcA ^ srcB;
            cpuPkg::ALU_SLT: resE_o = {31'b0, $signed(srcA) < $signed(srcB)};
            cpuPkg::ALU_SLL: resE_o = srcB << shamtE;
            default:         resE_o = srcB;     // lui, immediate already in the upper half
        endcase
    end

    assign wenE_o = validE && regWriteE;
    assign wenM_o = validM && regWriteM;
    assign wenW_o = validW && regWriteW;

    noZeroWrite: assert property (@(posedge clk) disable iff (!rstN_i) wenW_o |-> wregW_o != '0)
        else $error("write-back to r0 reached W");

endmodule

//--- src/datapath.sv
`timescale 1ns/10ps

module datapath (
    input  logic             clk,
    input  logic             rstN_i,
    input  logic             iCacheStall_i,
    input  cpuPkg::word_t    inst1F2_i,
    input  cpuPkg::word_t    inst2F2_i,
    output cpuPkg::word_t    pcIf1_o,
    output logic             instEn_o,
    output cpuPkg::word_t    dbgWbPc1_o, dbgWbPc2_o,
    output logic [3:0]       dbgWbWen1_o, dbgWbWen2_o,
    output cpuPkg::regAddr_t dbgWbWnum1_o, dbgWbWnum2_o,
    output cpuPkg::word_t    dbgWbWdata1_o, dbgWbWdata2_o
);

    cpuPkg::word_t    pcF2, inst1F2, inst2F2, pcD, pc2D, instr1D, instr2D, redirectPc;
    logic             validF2, validD;
    logic             stallF, stallD, flushF2, bubble2, bubbleE, redirect;
    cpuPkg::aluOp_e   aluOp1, aluOp2;
    logic             useImm1, useImm2, readsRs1, readsRt1, readsRs2, readsRt2;
    logic             regWrite1, regWrite2;
    cpuPkg::word_t    imm1, imm2, rdata1, rdata2, rdata3, rdata4;
    cpuPkg::word_t    opA1, opB1, opA2, opB2;
    cpuPkg::shamt_t   shamt1, shamt2;
    cpuPkg::regAddr_t rs1, rt1, rs2, rt2, wreg1, wreg2;
    cpuPkg::word_t    resE1, resM1, resW1, resE2, resM2, resW2, pcW1, pcW2;
    cpuPkg::regAddr_t wregE1, wregM1, wregW1, wregE2, wregM2, wregW2;
    logic             wenE1, wenM1, wenW1, wenE2, wenM2, wenW2;

    fetchUnit fetch_i (
        .clk(clk), .rstN_i(rstN_i), .stallF_i(stallF), .flushF2_i(flushF2),
        .redirect_i(redirect), .redirectPc_i(redirectPc),
        .inst1_i(inst1F2_i), .inst2_i(inst2F2_i), .pc_o(pcIf1_o), .instEn_o(instEn_o),
        .pcF2_o(pcF2), .inst1F2_o(inst1F2), .inst2F2_o(inst2F2), .validF2_o(validF2)
    );

    // D holds the pair under the cache stall, a split empties it
    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            validD <= 1'b0;
        end else if (!stallD) begin
            validD <= validF2 && !flushF2;
        end
    end

    always_ff @(posedge clk) begin
        if (!stallD) begin
            pcD     <= pcF2;
            instr1D <= inst1F2;
            instr2D <= inst2F2;
        end
    end

    assign pc2D = pcD + cpuPkg::INST_STEP;

    instDecoder dec1_i (
        .instr_i(instr1D), .aluOp_o(aluOp1), .useImm_o(useImm1), .imm_o(imm1),
        .shamt_o(shamt1), .rs_o(rs1), .rt_o(rt1), .readsRs_o(readsRs1), .readsRt_o(readsRt1),
        .writeReg_o(wreg1), .regWrite_o(regWrite1)
    );

    instDecoder dec2_i (
        .instr_i(instr2D), .aluOp_o(aluOp2), .useImm_o(useImm2), .imm_o(imm2),
        .shamt_o(shamt2), .rs_o(rs2), .rt_o(rt2), .readsRs_o(readsRs2), .readsRt_o(readsRt2),
        .writeReg_o(wreg2), .regWrite_o(regWrite2)
    );

    regFile rf_i (
        .clk(clk), .rstN_i(rstN_i), .we1_i(wenW1), .we2_i(wenW2),
        .waddr1_i(wregW1), .waddr2_i(wregW2), .wdata1_i(resW1), .wdata2_i(resW2),
        .raddr1_i(rs1), .raddr2_i(rt1), .raddr3_i(rs2), .raddr4_i(rt2),
        .rdata1_o(rdata1), .rdata2_o(rdata2), .rdata3_o(rdata3), .rdata4_o(rdata4)
    );

    issueCtrl issue_i (
        .iCacheStall_i(iCacheStall_i), .validD_i(validD), .regWrite1_i(regWrite1),
        .writeReg1_i(wreg1), .rs2_i(rs2), .rt2_i(rt2), .readsRs2_i(readsRs2),
        .readsRt2_i(readsRt2), .pcD_i(pcD), .stallF_o(stallF), .stallD_o(stallD),
        .flushF2_o(flushF2), .bubble2_o(bubble2), .bubbleE_o(bubbleE),
        .redirect_o(redirect), .redirectPc_o(redirectPc)
    );

    bypassNet bypass_i (
        .raddrA1_i(rs1), .raddrB1_i(rt1), .raddrA2_i(rs2), .raddrB2_i(rt2),
        .useA1_i(readsRs1), .useB1_i(readsRt1), .useA2_i(readsRs2), .useB2_i(readsRt2),
        .rdataA1_i(rdata1), .rdataB1_i(rdata2), .rdataA2_i(rdata3), .rdataB2_i(rdata4),
        .wregE1_i(wregE1), .wregM1_i(wregM1), .wregW1_i(wregW1),
        .wregE2_i(wregE2), .wregM2_i(wregM2), .wregW2_i(wregW2),
        .wenE1_i(wenE1), .wenM1_i(wenM1), .wenW1_i(wenW1),
        .wenE2_i(wenE2), .wenM2_i(wenM2), .wenW2_i(wenW2),
        .resE1_i(resE1), .resM1_i(resM1), .resW1_i(resW1),
        .resE2_i(resE2), .resM2_i(resM2), .resW2_i(resW2),
        .opA1_o(opA1), .opB1_o(opB1), .opA2_o(opA2), .opB2_o(opB2)
    );

    execLane lane1_i (
        .clk(clk), .rstN_i(rstN_i), .bubble_i(bubbleE), .valid_i(validD), .pc_i(pcD),
        .aluOp_i(aluOp1), .opA_i(opA1), .opB_i(opB1), .imm_i(imm1), .useImm_i(useImm1),
        .shamt_i(shamt1), .writeReg_i(wreg1), .regWrite_i(regWrite1),
        .resE_o(resE1), .resM_o(resM1), .resW_o(resW1),
        .wregE_o(wregE1), .wregM_o(wregM1), .wregW_o(wregW1),
        .wenE_o(wenE1), .wenM_o(wenM1), .wenW_o(wenW1), .pcW_o(pcW1)
    );

    // slave also drops out when the pair is split
    execLane lane2_i (
        .clk(clk), .rstN_i(rstN_i), .bubble_i(bubbleE | bubble2), .valid_i(validD),
        .pc_i(pc2D), .aluOp_i(aluOp2), .opA_i(opA2), .opB_i(opB2), .imm_i(imm2),
        .useImm_i(useImm2), .shamt_i(shamt2), .writeReg_i(wreg2), .regWrite_i(regWrite2),
        .resE_o(resE2), .resM_o(resM2), .resW_o(resW2),
        .wregE_o(wregE2), .wregM_o(wregM2), .wregW_o(wregW2),
        .wenE_o(wenE2), .wenM_o(wenM2), .wenW_o(wenW2), .pcW_o(pcW2)
    );

    assign dbgWbPc1_o    = pcW1;
    assign dbgWbWen1_o   = {4{wenW1}};     // byte enables, all or nothing
    assign dbgWbWnum1_o  = wregW1;
    assign dbgWbWdata1_o = resW1;
    assign dbgWbPc2_o    = pcW2;
    assign dbgWbWen2_o   = {4{wenW2}};
    assign dbgWbWnum2_o  = wregW2;
    assign dbgWbWdata2_o = resW2;

endmodule

//--- tb/datapathTb.sv
`timescale 1ns/10ps

module datapathTb;

    localparam int NUM_TESTS      = 6;
    localparam int TIMEOUT_CYCLES = 400 * NUM_TESTS;

    logic             clk = 1'b0;
    logic             rstN;
    logic             stall;
    cpuPkg::word_t    inst1F2, inst2F2, pcIf1;
    logic             instEn;
    cpuPkg::word_t    dbgWbPc1, dbgWbPc2, dbgWbWdata1, dbgWbWdata2;
    logic [3:0]       dbgWbWen1, dbgWbWen2;
    cpuPkg::regAddr_t dbgWbWnum1, dbgWbWnum2;

    cpuPkg::word_t prog [64];
    int            progLen;
    cpuPkg::word_t reqPc;               // pair the ROM answers with
    cpuPkg::word_t expPc [$];
    cpuPkg::word_t expReg [$];
    cpuPkg::word_t expVal [$];

    string         testName;
    int            errCount, errAtStart, passCount, failCount, cycleCount;
    logic          monitorOn, stallEn, sawWrite;
    cpuPkg::word_t firstPc;
    int            stallLeft;
    logic [31:0]   stallRnd;
    integer        seed;

    datapath datapath_i (
        .clk(clk), .rstN_i(rstN), .iCacheStall_i(stall),
        .inst1F2_i(inst1F2), .inst2F2_i(inst2F2), .pcIf1_o(pcIf1), .instEn_o(instEn),
        .dbgWbPc1_o(dbgWbPc1), .dbgWbPc2_o(dbgWbPc2),
        .dbgWbWen1_o(dbgWbWen1), .dbgWbWen2_o(dbgWbWen2),
        .dbgWbWnum1_o(dbgWbWnum1), .dbgWbWnum2_o(dbgWbWnum2),
        .dbgWbWdata1_o(dbgWbWdata1), .dbgWbWdata2_o(dbgWbWdata2)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("timeout: %s still waits for write-backs after %0d cycles",
                     testName, cycleCount);
            $display("Simulation failed");
            $finish;
        end
    end

    // registered ROM, a request counts only when enabled and not stalled
    always @(posedge clk) begin
        if (instEn === 1'b1 && stall === 1'b0) begin
            reqPc = pcIf1;
        end
    end

    function automatic cpuPkg::word_t romRead(input cpuPkg::word_t addr);
        logic [31:0] idx;
        idx = (addr - cpuPkg::RESET_PC) >> 2;
        if (idx < 32'(progLen)) begin
            return prog[idx[5:0]];
        end
        return '0;                          // outside the program, NOP
    endfunction

    always @(negedge clk) begin
        inst1F2 = romRead(reqPc);
        inst2F2 = romRead(reqPc + 32'd4);
        if (!stallEn) begin
            stall     = 1'b0;
            stallLeft = 0;
        end else if (stallLeft > 0) begin
            stall = 1'b1;
            stallLeft--;
        end else begin
            stall    = 1'b0;
            stallRnd = $random(seed);
            if (stallRnd[2:0] == 3'd0) begin
                stallLeft = int'(stallRnd[5:4]) + 1;    // burst of 1 to 4 cycles
            end
        end
    end

    task automatic checkEq(input string what, input logic [31:0] expV, input logic [31:0] actV);
        if (actV !== expV) begin
            $display("Fail %s %s: expected %h, actual %h", testName, what, expV, actV);
            errCount++;
        end
    endtask

    task automatic checkLane(input logic [3:0] wen, input cpuPkg::word_t pc,
                             input cpuPkg::regAddr_t num, input cpuPkg::word_t data);
        if (wen === 4'hF) begin
            if (expPc.size() == 0) begin
                $display("%s: write-back of r%0d at pc %h after the last expected write",
                         testName, num, pc);
                errCount++;
            end else begin
                if (!sawWrite) begin
                    firstPc = pc;
                end
                sawWrite = 1'b1;
                checkEq("pc", expPc.pop_front(), pc);
                checkEq("reg", expReg.pop_front(), {27'h0, num});
                checkEq("value", expVal.pop_front(), data);
            end
        end else if (wen !== 4'h0) begin
            $display("%s: debug write enable is %b, neither all set nor all clear",
                     testName, wen);
            errCount++;
        end
    endtask

    // lane 1 is the older write of a cycle
    always @(negedge clk) begin
        if (monitorOn) begin
            checkLane(dbgWbWen1, dbgWbPc1, dbgWbWnum1, dbgWbWdata1);
            checkLane(dbgWbWen2, dbgWbPc2, dbgWbWnum2, dbgWbWdata2);
        end
    end

    function automatic cpuPkg::word_t encR(input logic [5:0] fn, input int rd, input int rs,
                                           input int rt, input int sh);
        return {cpuPkg::OP_SPECIAL, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
    endfunction

    function automatic cpuPkg::word_t encI(input logic [5:0] op, input int rt, input int rs,
                                           input logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    task automatic addInst(input cpuPkg::word_t w);
        prog[progLen[5:0]] = w;
        progLen++;
    endtask

    // sequential ISA model, one entry per write to a nonzero register
    task automatic buildExpected();
        logic [31:0] regs [32];
        logic [31:0] w, a, b, res;
        logic [4:0]  dest;
        logic        wr;
        for (int r = 0; r < 32; r++) begin
            regs[r] = '0;
        end
        expPc.delete();
        expReg.delete();
        expVal.delete();
        for (int i = 0; i < progLen; i++) begin
            w    = prog[i[5:0]];
            a    = regs[w[25:21]];
            b    = regs[w[20:16]];
            dest = w[20:16];
            wr   = 1'b1;
            res  = '0;
            case (w[31:26])
                cpuPkg::OP_SPECIAL: begin
                    dest = w[15:11];
                    case (w[5:0])
                        cpuPkg::FN_ADDU: res = a + b;
                        cpuPkg::FN_SUBU: res = a - b;
                        cpuPkg::FN_AND:  res = a & b;
                        cpuPkg::FN_OR:   res = a | b;
                        cpuPkg::FN_XOR:  res = a ^ b;
                        cpuPkg::FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        cpuPkg::FN_SLL:  res = b << w[10:6];
                        default:         wr = 1'b0;
                    endcase
                end
                cpuPkg::OP_ADDIU: res = a + {{16{w[15]}}, w[15:0]};
                cpuPkg::OP_ORI:   res = a | {16'h0000, w[15:0]};
                cpuPkg::OP_LUI:   res = {w[15:0], 16'h0000};
                default:          wr = 1'b0;
            endcase
            if (wr && dest != 5'd0) begin
                regs[dest] = res;
                expPc.push_back(cpuPkg::RESET_PC + 32'(4 * i));
                expReg.push_back({27'h0, dest});
                expVal.push_back(res);
            end
        end
    endtask

    task automatic resetDut();
        @(negedge clk);
        rstN = 1'b0;
        repeat (8) begin
            @(negedge clk);
            checkEq("wen in reset", 32'h0, {24'h0, dbgWbWen1, dbgWbWen2});
        end
        checkEq("pc in reset", cpuPkg::RESET_PC, pcIf1);
        checkEq("instEn in reset", 32'h1, {31'h0, instEn});
        rstN = 1'b1;
        repeat (3) begin
            @(negedge clk);
            checkEq("wen after reset", 32'h0, {24'h0, dbgWbWen1, dbgWbWen2});
        end
        @(posedge clk);
    endtask

    task automatic runProgram(input logic withStall);
        buildExpected();
        resetDut();
        monitorOn = 1'b1;
        stallEn   = withStall;
        while (expPc.size() != 0) begin
            @(posedge clk);
        end
        repeat (6) @(posedge clk);          // catches late duplicates
        monitorOn = 1'b0;
        stallEn   = 1'b0;
    endtask

    task automatic startTest(input string name);
        testName   = name;
        errAtStart = errCount;
        progLen    = 0;
        sawWrite   = 1'b0;
        firstPc    = '0;
    endtask

    task automatic finishTest();
        if (errCount == errAtStart) begin
            passCount++;
            $display("%s passed", testName);
        end else begin
            failCount++;
            $display("%s failed with %0d errors", testName, errCount - errAtStart);
        end
    endtask

    task automatic loadBypassProg();
        addInst(encI(cpuPkg::OP_ADDIU, 1, 0, 16'd10));
        addInst(encI(cpuPkg::OP_ADDIU, 2, 0, 16'd20));
        addInst(encR(cpuPkg::FN_ADDU, 3, 1, 2, 0));     // r1, r2 from E
        addInst(encR(cpuPkg::FN_SUBU, 4, 2, 1, 0));
        addInst(encR(cpuPkg::FN_ADDU, 5, 3, 1, 0));     // r1 from M
        addInst(encR(cpuPkg::FN_OR, 6, 4, 0, 0));
        addInst(encR(cpuPkg::FN_XOR, 7, 5, 3, 0));
        addInst(encR(cpuPkg::FN_ADDU, 8, 2, 4, 0));     // r2 from W
        addInst(encR(cpuPkg::FN_SLT, 9, 4, 7, 0));
        addInst(encR(cpuPkg::FN_SLL, 10, 0, 6, 3));
        addInst(encR(cpuPkg::FN_SUBU, 11, 10, 1, 0));   // r1 from the register file
        addInst(encI(cpuPkg::OP_ADDIU, 12, 9, 16'd7));
    endtask

    task automatic testReset();
        startTest("testReset");
        addInst(encI(cpuPkg::OP_ADDIU, 1, 0, 16'd5));
        addInst(encI(cpuPkg::OP_ADDIU, 2, 0, 16'd7));
        addInst(encR(cpuPkg::FN_ADDU, 3, 1, 2, 0));
        addInst(encR(cpuPkg::FN_SUBU, 4, 2, 1, 0));
        runProgram(1'b0);
        checkEq("first pc", cpuPkg::RESET_PC, firstPc);
        finishTest();
    endtask

    task automatic testIndependent();
        startTest("testIndependent");
        addInst(encI(cpuPkg::OP_LUI, 1, 0, 16'h1234));
        addInst(encI(cpuPkg::OP_ADDIU, 2, 0, 16'hFFFD));
        addInst(encI(cpuPkg::OP_ORI, 3, 0, 16'h00F0));
        addInst(encI(cpuPkg::OP_ADDIU, 4, 0, 16'd100));
        addInst(encR(cpuPkg::FN_ADDU, 5, 1, 2, 0));
        addInst(encR(cpuPkg::FN_SUBU, 6, 4, 3, 0));
        addInst(encR(cpuPkg::FN_AND, 7, 2, 4, 0));
        addInst(encR(cpuPkg::FN_OR, 8, 1, 3, 0));
        addInst(encR(cpuPkg::FN_XOR, 9, 2, 4, 0));
        addInst(encR(cpuPkg::FN_SLT, 10, 2, 4, 0));
        addInst(encR(cpuPkg::FN_SLL, 11, 0, 4, 4));
        addInst(encI(cpuPkg::OP_ADDIU, 11, 0, 16'd9));  // same target, slave wins
        addInst(encR(cpuPkg::FN_ADDU, 12, 11, 0, 0));
        addInst(encR(cpuPkg::FN_SLT, 13, 4, 2, 0));
        runProgram(1'b0);
        finishTest();
    endtask

    task automatic testBypass();
        startTest("testBypass");
        loadBypassProg();
        runProgram(1'b0);
        finishTest();
    endtask

    task automatic testSplit();
        startTest("testSplit");
        addInst(encI(cpuPkg::OP_ADDIU, 1, 0, 16'd3));
        addInst(encR(cpuPkg::FN_ADDU, 2, 1, 1, 0));
        addInst(encI(cpuPkg::OP_ORI, 3, 2, 16'h0100));
        addInst(encI(cpuPkg::OP_ADDIU, 6, 0, 16'hFFFF));
        addInst(encR(cpuPkg::FN_SLL, 4, 0, 3, 2));
        addInst(encR(cpuPkg::FN_SUBU, 5, 4, 1, 0));
        addInst(encR(cpuPkg::FN_XOR, 7, 5, 6, 0));
        addInst(encI(cpuPkg::OP_ADDIU, 8, 7, 16'd1));
        addInst(encR(cpuPkg::FN_ADDU, 9, 0, 8, 0));     // dependence through rt
        runProgram(1'b0);
        finishTest();
    endtask

    task automatic testZeroReg();
        startTest("testZeroReg");
        addInst(encI(cpuPkg::OP_ADDIU, 0, 0, 16'd55));
        addInst(encI(cpuPkg::OP_ADDIU, 1, 0, 16'd7));
        addInst(encR(cpuPkg::FN_ADDU, 0, 1, 1, 0));
        addInst(encR(cpuPkg::FN_OR, 2, 0, 1, 0));
        addInst(32'hFC00_0000);                         // unknown opcode
        addInst(encI(cpuPkg::OP_LUI, 0, 0, 16'hFFFF));
        addInst(encR(cpuPkg::FN_ADDU, 3, 0, 0, 0));
        addInst(encR(cpuPkg::FN_SLT, 4, 0, 1, 0));
        runProgram(1'b0);
        finishTest();
    endtask

    task automatic testCacheStall();
        startTest("testCacheStall");
        loadBypassProg();
        runProgram(1'b1);
        finishTest();
    endtask

    initial begin
        rstN       = 1'b0;
        stall      = 1'b0;
        inst1F2    = '0;
        inst2F2    = '0;
        reqPc      = cpuPkg::RESET_PC;
        monitorOn  = 1'b0;
        stallEn    = 1'b0;
        stallLeft  = 0;
        seed       = 84545;
        errCount   = 0;
        passCount  = 0;
        failCount  = 0;
        cycleCount = 0;
        progLen    = 0;
        testName   = "setup";
        testReset();
        testIndependent();
        testBypass();
        testSplit();
        testZeroReg();
        testCacheStall();
        $display("tests passed: %0d, tests failed: %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- project.f
src/cpuPkg.sv
src/fetchUnit.sv
src/instDecoder.sv
src/regFile.sv
src/issueCtrl.sv
src/bypassNet.sv
src/execLane.sv
src/datapath.sv
tb/datapathTb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module datapathTb -f project.f -o datapathSim &&
./obj_dir/datapathSim | grep "Simulation completed successfully" &&
echo "run passed" || { echo "run failed"; exit 1; }
